// ==== common/axi_defs.svh ====
`ifndef AXI_DEFS_SVH
`define AXI_DEFS_SVH

`define XLEN                 64
`define AXI_ID_WIDTH         4
`define AXI_USER_WIDTH       1
`define AXI_STRB_WIDTH       8

`define AXI_ID_VALUE         4'd1

// unprivileged | secure | data access, all encoded as zero
`define AXI_PROT_DATA        3'b000

`define AXI_ARCACHE_NONCACHE 4'b0000 // device non-bufferable
`define AXI_AWCACHE_WB_ALLOC 4'b1111 // write-back, read and write allocate

// 64-bit words in the sram, as a power of two
`define SRAM_DEPTH_LOG2      10

`endif

// ==== common/axi_pkg.sv ====
`include "axi_defs.svh"

package axi_pkg;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_e;

    typedef enum logic [1:0] {
        FIXED = 2'b00,
        INCR  = 2'b01,
        WRAP  = 2'b10
    } axi_burst_e;

    // bytes per beat
    typedef enum logic [2:0] {
        SIZE_1   = 3'd0,
        SIZE_2   = 3'd1,
        SIZE_4   = 3'd2,
        SIZE_8   = 3'd3,
        SIZE_16  = 3'd4,
        SIZE_32  = 3'd5,
        SIZE_64  = 3'd6,
        SIZE_128 = 3'd7
    } axi_size_e;

endpackage

// ==== common/lsu_pkg.sv ====
`include "axi_defs.svh"

package lsu_pkg;

    // bridge write side
    typedef enum logic [1:0] {
        WR_IDLE = 2'b00,
        WR_AW   = 2'b01,
        WR_W    = 2'b11,
        WR_B    = 2'b10
    } wr_state_e;

    // bridge read side
    typedef enum logic [1:0] {
        RD_IDLE = 2'b00,
        RD_AR   = 2'b01,
        RD_R    = 2'b11,
        RD_DONE = 2'b10
    } rd_state_e;

    // memory write side, reads are tracked by r_valid
    typedef enum logic [1:0] {
        SR_IDLE  = 2'b00,
        SR_WDATA = 2'b01,
        SR_BRESP = 2'b10
    } sram_state_e;

endpackage

// ==== axi_ls/axi_ls.sv ====
`timescale 1ns/1ps
`include "axi_defs.svh"

module axi_ls (
    input  logic                         clock,
    input  logic                         reset,

    input  logic                         wr_valid_i,
    input  logic                         rd_valid_i,
    input  logic [`XLEN-1:0]             addr_i,
    input  logic [`XLEN-1:0]             wr_data_i,
    input  logic [`AXI_STRB_WIDTH-1:0]   wr_mask_i,
    input  axi_pkg::axi_size_e           wr_size_i,
    input  axi_pkg::axi_size_e           rd_size_i,
    output logic                         wr_ok_o,
    output logic                         rd_ready_o,
    output logic [`XLEN-1:0]             rd_data_o,

    output logic                         axi_aw_valid_o,
    input  logic                         axi_aw_ready_i,
    output logic [`XLEN-1:0]             axi_aw_addr_o,
    output logic [`AXI_ID_WIDTH-1:0]     axi_aw_id_o,
    output logic [7:0]                   axi_aw_len_o,
    output axi_pkg::axi_size_e           axi_aw_size_o,
    output axi_pkg::axi_burst_e          axi_aw_burst_o,
    output logic [2:0]                   axi_aw_prot_o,
    output logic [3:0]                   axi_aw_cache_o,

    output logic                         axi_w_valid_o,
    input  logic                         axi_w_ready_i,
    output logic [`XLEN-1:0]             axi_w_data_o,
    output logic [`AXI_STRB_WIDTH-1:0]   axi_w_strb_o,
    output logic                         axi_w_last_o,

    input  logic                         axi_b_valid_i,
    output logic                         axi_b_ready_o,
    input  axi_pkg::axi_resp_e           axi_b_resp_i,

    output logic                         axi_ar_valid_o,
    input  logic                         axi_ar_ready_i,
    output logic [`XLEN-1:0]             axi_ar_addr_o,
    output logic [`AXI_ID_WIDTH-1:0]     axi_ar_id_o,
    output logic [7:0]                   axi_ar_len_o,
    output axi_pkg::axi_size_e           axi_ar_size_o,
    output axi_pkg::axi_burst_e          axi_ar_burst_o,
    output logic [2:0]                   axi_ar_prot_o,
    output logic [3:0]                   axi_ar_cache_o,

    input  logic                         axi_r_valid_i,
    output logic                         axi_r_ready_o,
    input  logic [`XLEN-1:0]             axi_r_data_i,
    input  axi_pkg::axi_resp_e           axi_r_resp_i,
    input  logic                         axi_r_last_i
);

    import axi_pkg::*;
    import lsu_pkg::*;

    wr_state_e                  wr_state;
    wr_state_e                  wr_state_next;
    rd_state_e                  rd_state;
    rd_state_e                  rd_state_next;

    logic [`XLEN-1:0]           wr_addr_q;
    logic [`XLEN-1:0]           wr_data_q;
    logic [`AXI_STRB_WIDTH-1:0] wr_mask_q;
    axi_size_e                  wr_size_q;
    logic                       wr_done_q;
    logic [`XLEN-1:0]           rd_addr_q;
    logic [`XLEN-1:0]           rd_data_q;
    axi_size_e                  rd_size_q;

    logic                       wr_load;
    logic                       rd_load;
    logic                       wr_match;
    logic                       rd_match;

    assign wr_match = (addr_i == wr_addr_q) && (wr_data_i == wr_data_q);
    assign rd_match = (addr_i == rd_addr_q);

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            wr_state <= WR_IDLE;
            rd_state <= RD_IDLE;
        end else begin
            wr_state <= wr_state_next;
            rd_state <= rd_state_next;
        end
    end

    always_comb begin
        wr_state_next = wr_state;
        case (wr_state)
            WR_IDLE: if (wr_valid_i) wr_state_next = WR_AW;
            WR_AW:   if (axi_aw_ready_i) wr_state_next = WR_W;
            WR_W:    if (axi_w_ready_i) wr_state_next = WR_B;
            WR_B: begin
                // leave only once b is taken, else the slave stays blocked
                if (wr_done_q) begin
                    if (!wr_valid_i) wr_state_next = WR_IDLE;
                    else if (!wr_match) wr_state_next = WR_AW;
                end
            end
            default: wr_state_next = WR_IDLE;
        endcase
    end

    always_comb begin
        rd_state_next = rd_state;
        case (rd_state)
            RD_IDLE: if (rd_valid_i) rd_state_next = RD_AR;
            RD_AR:   if (axi_ar_ready_i) rd_state_next = RD_R;
            RD_R:    if (axi_r_valid_i) rd_state_next = RD_DONE;
            RD_DONE: begin
                if (!rd_valid_i) rd_state_next = RD_IDLE;
                else if (!rd_match) rd_state_next = RD_AR; // new address, re-issue
            end
            default: rd_state_next = RD_IDLE;
        endcase
    end

    assign wr_load = (wr_state_next == WR_AW) && (wr_state != WR_AW);
    assign rd_load = (rd_state_next == RD_AR) && (rd_state != RD_AR);

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            wr_done_q <= 1'b0;
        end else if (wr_load) begin
            wr_done_q <= 1'b0;
        end else if (axi_b_valid_i && axi_b_ready_o) begin
            wr_done_q <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (wr_load) begin
            wr_addr_q <= addr_i;
            wr_data_q <= wr_data_i;
            wr_mask_q <= wr_mask_i;
            wr_size_q <= wr_size_i;
        end
        if (rd_load) begin
            rd_addr_q <= addr_i;
            rd_size_q <= rd_size_i;
        end
        if (axi_r_valid_i && axi_r_ready_o) begin
            rd_data_q <= axi_r_data_i;
        end
    end

    assign axi_aw_valid_o = (wr_state == WR_AW);
    assign axi_aw_addr_o  = wr_addr_q;
    assign axi_aw_id_o    = `AXI_ID_VALUE;
    assign axi_aw_len_o   = 8'd0;        // single beat
    assign axi_aw_size_o  = wr_size_q;
    assign axi_aw_burst_o = INCR;
    assign axi_aw_prot_o  = `AXI_PROT_DATA;
    assign axi_aw_cache_o = `AXI_AWCACHE_WB_ALLOC;

    assign axi_w_valid_o  = (wr_state == WR_W);
    assign axi_w_data_o   = wr_data_q << {wr_addr_q[2:0], 3'b000}; // into byte lane
    assign axi_w_strb_o   = wr_mask_q << wr_addr_q[2:0];
    assign axi_w_last_o   = axi_w_valid_o;

    assign axi_b_ready_o  = (wr_state == WR_B) && !wr_done_q;
    assign wr_ok_o        = (wr_state == WR_B) && wr_done_q && wr_match;

    assign axi_ar_valid_o = (rd_state == RD_AR);
    assign axi_ar_addr_o  = rd_addr_q;
    assign axi_ar_id_o    = `AXI_ID_VALUE;
    assign axi_ar_len_o   = 8'd0;
    assign axi_ar_size_o  = rd_size_q;
    assign axi_ar_burst_o = INCR;
    assign axi_ar_prot_o  = `AXI_PROT_DATA;
    assign axi_ar_cache_o = `AXI_ARCACHE_NONCACHE;

    assign axi_r_ready_o  = (rd_state == RD_R);
    assign rd_ready_o     = (rd_state == RD_DONE) && rd_match;
    assign rd_data_o      = rd_ready_o ? rd_data_q : '0;

    a_aw_hold: assert property (@(posedge clock) disable iff (!reset)
        axi_aw_valid_o && !axi_aw_ready_i |=> axi_aw_valid_o);

    a_aw_w_excl: assert property (@(posedge clock) disable iff (!reset)
        !(axi_aw_valid_o && axi_w_valid_o));

    // slave only ever answers okay with one beat
    a_resp_okay: assert property (@(posedge clock) disable iff (!reset)
        (axi_b_valid_i && axi_b_ready_o |-> axi_b_resp_i == OKAY) and
        (axi_r_valid_i && axi_r_ready_o |-> axi_r_resp_i == OKAY && axi_r_last_i));

endmodule

// ==== verilog/axi_sram.sv ====
`timescale 1ns/1ps
`include "axi_defs.svh"

module axi_sram (
    input  logic                         clock,
    input  logic                         reset,

    input  logic                         axi_aw_valid_i,
    output logic                         axi_aw_ready_o,
    input  logic [`XLEN-1:0]             axi_aw_addr_i,
    input  logic [7:0]                   axi_aw_len_i,
    input  axi_pkg::axi_size_e           axi_aw_size_i,
    input  axi_pkg::axi_burst_e          axi_aw_burst_i,

    input  logic                         axi_w_valid_i,
    output logic                         axi_w_ready_o,
    input  logic [`XLEN-1:0]             axi_w_data_i,
    input  logic [`AXI_STRB_WIDTH-1:0]   axi_w_strb_i,
    input  logic                         axi_w_last_i,

    output logic                         axi_b_valid_o,
    input  logic                         axi_b_ready_i,
    output axi_pkg::axi_resp_e           axi_b_resp_o,

    input  logic                         axi_ar_valid_i,
    output logic                         axi_ar_ready_o,
    input  logic [`XLEN-1:0]             axi_ar_addr_i,
    input  logic [7:0]                   axi_ar_len_i,
    input  axi_pkg::axi_size_e           axi_ar_size_i,
    input  axi_pkg::axi_burst_e          axi_ar_burst_i,

    output logic                         axi_r_valid_o,
    input  logic                         axi_r_ready_i,
    output logic [`XLEN-1:0]             axi_r_data_o,
    output axi_pkg::axi_resp_e           axi_r_resp_o,
    output logic                         axi_r_last_o
);

    import axi_pkg::*;
    import lsu_pkg::*;

    logic [`XLEN-1:0]             mem [0:(1 << `SRAM_DEPTH_LOG2)-1];

    sram_state_e                  state;
    sram_state_e                  state_next;
    logic [`SRAM_DEPTH_LOG2-1:0]  wr_idx_q;
    logic [`XLEN-1:0]             r_data_q;
    logic                         r_valid_q;

    assign axi_aw_ready_o = (state == SR_IDLE) && !r_valid_q;
    assign axi_ar_ready_o = (state == SR_IDLE) && !r_valid_q && !axi_aw_valid_i; // write wins
    assign axi_w_ready_o  = (state == SR_WDATA);
    assign axi_b_valid_o  = (state == SR_BRESP);
    assign axi_b_resp_o   = OKAY;

    always_comb begin
        state_next = state;
        case (state)
            SR_IDLE:  if (axi_aw_valid_i && axi_aw_ready_o) state_next = SR_WDATA;
            SR_WDATA: if (axi_w_valid_i) state_next = SR_BRESP;
            SR_BRESP: if (axi_b_ready_i) state_next = SR_IDLE;
            default:  state_next = SR_IDLE;
        endcase
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state     <= SR_IDLE;
            r_valid_q <= 1'b0;
        end else begin
            state <= state_next;
            if (axi_ar_valid_i && axi_ar_ready_o) begin
                r_valid_q <= 1'b1;
            end else if (axi_r_ready_i) begin
                r_valid_q <= 1'b0;
            end
        end
    end

    // word index, byte offset dropped
    always_ff @(posedge clock) begin
        if (axi_aw_valid_i && axi_aw_ready_o) begin
            wr_idx_q <= axi_aw_addr_i[`SRAM_DEPTH_LOG2+2:3];
        end
        if (axi_ar_valid_i && axi_ar_ready_o) begin
            r_data_q <= mem[axi_ar_addr_i[`SRAM_DEPTH_LOG2+2:3]];
        end
    end

    always_ff @(posedge clock) begin
        if (axi_w_valid_i && axi_w_ready_o) begin
            for (int b = 0; b < `AXI_STRB_WIDTH; b++) begin
                if (axi_w_strb_i[b]) mem[wr_idx_q][b*8 +: 8] <= axi_w_data_i[b*8 +: 8];
            end
        end
    end

    assign axi_r_valid_o = r_valid_q;
    assign axi_r_data_o  = r_data_q;
    assign axi_r_resp_o  = OKAY;
    assign axi_r_last_o  = r_valid_q;

    a_b_hold: assert property (@(posedge clock) disable iff (!reset)
        axi_b_valid_o && !axi_b_ready_i |=> axi_b_valid_o);

    // no bursts and nothing wider than the bus from the master
    a_single_beat: assert property (@(posedge clock) disable iff (!reset)
        (axi_aw_valid_i && axi_aw_ready_o |->
            axi_aw_len_i == 8'd0 && axi_aw_burst_i == INCR && axi_aw_size_i <= SIZE_8) and
        (axi_ar_valid_i && axi_ar_ready_o |->
            axi_ar_len_i == 8'd0 && axi_ar_burst_i == INCR && axi_ar_size_i <= SIZE_8) and
        (axi_w_valid_i && axi_w_ready_o |-> axi_w_last_i));

endmodule

// ==== verilog/ls_subsys_top.sv ====
`timescale 1ns/1ps
`include "axi_defs.svh"

module ls_subsys_top (
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         wr_valid_i,
    input  logic                         rd_valid_i,
    input  logic [`XLEN-1:0]             addr_i,
    input  logic [`XLEN-1:0]             wr_data_i,
    input  logic [`AXI_STRB_WIDTH-1:0]   wr_mask_i,
    input  axi_pkg::axi_size_e           wr_size_i,
    input  axi_pkg::axi_size_e           rd_size_i,
    output logic                         wr_ok_o,
    output logic                         rd_ready_o,
    output logic [`XLEN-1:0]             rd_data_o
);

    import axi_pkg::*;

    logic                       aw_valid;
    logic                       aw_ready;
    logic [`XLEN-1:0]           aw_addr;
    logic [7:0]                 aw_len;
    axi_size_e                  aw_size;
    axi_burst_e                 aw_burst;
    logic                       w_valid;
    logic                       w_ready;
    logic [`XLEN-1:0]           w_data;
    logic [`AXI_STRB_WIDTH-1:0] w_strb;
    logic                       w_last;
    logic                       b_valid;
    logic                       b_ready;
    axi_resp_e                  b_resp;
    logic                       ar_valid;
    logic                       ar_ready;
    logic [`XLEN-1:0]           ar_addr;
    logic [7:0]                 ar_len;
    axi_size_e                  ar_size;
    axi_burst_e                 ar_burst;
    logic                       r_valid;
    logic                       r_ready;
    logic [`XLEN-1:0]           r_data;
    axi_resp_e                  r_resp;
    logic                       r_last;

    // id, prot and cache are ignored by the memory
    axi_ls i_axi_ls (
        .clock          (clock),
        .reset          (reset),
        .wr_valid_i     (wr_valid_i),
        .rd_valid_i     (rd_valid_i),
        .addr_i         (addr_i),
        .wr_data_i      (wr_data_i),
        .wr_mask_i      (wr_mask_i),
        .wr_size_i      (wr_size_i),
        .rd_size_i      (rd_size_i),
        .wr_ok_o        (wr_ok_o),
        .rd_ready_o     (rd_ready_o),
        .rd_data_o      (rd_data_o),
        .axi_aw_valid_o (aw_valid),
        .axi_aw_ready_i (aw_ready),
        .axi_aw_addr_o  (aw_addr),
        .axi_aw_id_o    (),
        .axi_aw_len_o   (aw_len),
        .axi_aw_size_o  (aw_size),
        .axi_aw_burst_o (aw_burst),
        .axi_aw_prot_o  (),
        .axi_aw_cache_o (),
        .axi_w_valid_o  (w_valid),
        .axi_w_ready_i  (w_ready),
        .axi_w_data_o   (w_data),
        .axi_w_strb_o   (w_strb),
        .axi_w_last_o   (w_last),
        .axi_b_valid_i  (b_valid),
        .axi_b_ready_o  (b_ready),
        .axi_b_resp_i   (b_resp),
        .axi_ar_valid_o (ar_valid),
        .axi_ar_ready_i (ar_ready),
        .axi_ar_addr_o  (ar_addr),
        .axi_ar_id_o    (),
        .axi_ar_len_o   (ar_len),
        .axi_ar_size_o  (ar_size),
        .axi_ar_burst_o (ar_burst),
        .axi_ar_prot_o  (),
        .axi_ar_cache_o (),
        .axi_r_valid_i  (r_valid),
        .axi_r_ready_o  (r_ready),
        .axi_r_data_i   (r_data),
        .axi_r_resp_i   (r_resp),
        .axi_r_last_i   (r_last)
    );

    axi_sram i_axi_sram (
        .clock          (clock),
        .reset          (reset),
        .axi_aw_valid_i (aw_valid),
        .axi_aw_ready_o (aw_ready),
        .axi_aw_addr_i  (aw_addr),
        .axi_aw_len_i   (aw_len),
        .axi_aw_size_i  (aw_size),
        .axi_aw_burst_i (aw_burst),
        .axi_w_valid_i  (w_valid),
        .axi_w_ready_o  (w_ready),
        .axi_w_data_i   (w_data),
        .axi_w_strb_i   (w_strb),
        .axi_w_last_i   (w_last),
        .axi_b_valid_o  (b_valid),
        .axi_b_ready_i  (b_ready),
        .axi_b_resp_o   (b_resp),
        .axi_ar_valid_i (ar_valid),
        .axi_ar_ready_o (ar_ready),
        .axi_ar_addr_i  (ar_addr),
        .axi_ar_len_i   (ar_len),
        .axi_ar_size_i  (ar_size),
        .axi_ar_burst_i (ar_burst),
        .axi_r_valid_o  (r_valid),
        .axi_r_ready_i  (r_ready),
        .axi_r_data_o   (r_data),
        .axi_r_resp_o   (r_resp),
        .axi_r_last_o   (r_last)
    );

endmodule

// ==== verif/tb_ls_subsys.sv ====
`timescale 1ns/1ps
`include "axi_defs.svh"

module tb_ls_subsys;

    import axi_pkg::*;

    localparam int TIMEOUT = 200;
    localparam int WORDS   = 1 << `SRAM_DEPTH_LOG2;

    logic                       clock;
    logic                       reset;
    logic                       wr_valid;
    logic                       rd_valid;
    logic [`XLEN-1:0]           addr;
    logic [`XLEN-1:0]           wr_data;
    logic [`AXI_STRB_WIDTH-1:0] wr_mask;
    axi_size_e                  wr_size;
    axi_size_e                  rd_size;
    logic                       wr_ok;
    logic                       rd_ready;
    logic [`XLEN-1:0]           rd_data;

    logic [`XLEN-1:0]           model [0:WORDS-1];
    integer                     seed;

    ls_subsys_top i_dut (
        .clock      (clock),
        .reset      (reset),
        .wr_valid_i (wr_valid),
        .rd_valid_i (rd_valid),
        .addr_i     (addr),
        .wr_data_i  (wr_data),
        .wr_mask_i  (wr_mask),
        .wr_size_i  (wr_size),
        .rd_size_i  (rd_size),
        .wr_ok_o    (wr_ok),
        .rd_ready_o (rd_ready),
        .rd_data_o  (rd_data)
    );

    always #4 clock = ~clock;

    task automatic report_error(input string msg);
        $display("Simulation FAILED");
        $display("Error at %0t ns: %s", $time, msg);
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_timeout(input string what);
        $display("Simulation FAILED");
        $display("timed out after %0d cycles waiting for %s", TIMEOUT, what);
        $fatal(1, "stopped on timeout");
    endtask

    // byte lanes follow the low address bits
    function automatic void model_write(input logic [63:0] a, input logic [63:0] d,
                                        input logic [7:0] m);
        logic [7:0]  strb;
        logic [63:0] lane;
        int          idx;
        strb = m << a[2:0];
        lane = d << (8 * a[2:0]);
        idx  = a[`SRAM_DEPTH_LOG2+2:3];
        for (int b = 0; b < 8; b++) begin
            if (strb[b]) model[idx][8*b +: 8] = lane[8*b +: 8];
        end
    endfunction

    task automatic wait_wr_ok(input logic level);
        int n;
        n = 0;
        do begin
            @(negedge clock);
            n++;
        end while (wr_ok !== level && n < TIMEOUT);
        if (wr_ok !== level) report_timeout($sformatf("wr_ok_o to become %0b", level));
    endtask

    task automatic wait_rd_ready(input logic level);
        int n;
        n = 0;
        do begin
            @(negedge clock);
            n++;
        end while (rd_ready !== level && n < TIMEOUT);
        if (rd_ready !== level) report_timeout($sformatf("rd_ready_o to become %0b", level));
    endtask

    task automatic wait_both_done();
        int n;
        n = 0;
        do begin
            @(negedge clock);
            n++;
        end while (!(wr_ok === 1'b1 && rd_ready === 1'b1) && n < TIMEOUT);
        if (!(wr_ok === 1'b1 && rd_ready === 1'b1)) report_timeout("wr_ok_o and rd_ready_o");
    endtask

    task automatic check_read(input logic [63:0] a);
        logic [63:0] exp;
        exp = model[a[`SRAM_DEPTH_LOG2+2:3]];
        assert (rd_data === exp) else
            report_error($sformatf("read 0x%0h gave 0x%016h, expected 0x%016h", a, rd_data, exp));
    endtask

    task automatic do_write(input logic [63:0] a, input logic [63:0] d,
                            input logic [7:0] m, input axi_size_e sz);
        wr_valid = 1'b1;
        addr     = a;
        wr_data  = d;
        wr_mask  = m;
        wr_size  = sz;
        wait_wr_ok(1'b1);
        model_write(a, d, m);
        wr_valid = 1'b0;
        wait_wr_ok(1'b0);
    endtask

    task automatic do_read(input logic [63:0] a, output logic [63:0] got);
        rd_valid = 1'b1;
        addr     = a;
        rd_size  = SIZE_8;
        wait_rd_ready(1'b1);
        check_read(a);
        got      = rd_data;
        rd_valid = 1'b0;
        wait_rd_ready(1'b0);
    endtask

    task automatic test_hold_levels();
        logic [63:0] d;
        d = 64'h0bad_cafe_1234_5678;
        assert (wr_ok === 1'b0 && rd_ready === 1'b0) else
            report_error("done levels not low after reset");
        wr_valid = 1'b1;
        addr     = 64'hc0;
        wr_data  = d;
        wr_mask  = 8'hff;
        wr_size  = SIZE_8;
        wait_wr_ok(1'b1);
        model_write(64'hc0, d, 8'hff);
        repeat (5) begin
            @(negedge clock);
            assert (wr_ok === 1'b1) else report_error("wr_ok_o fell while write was held");
        end
        wr_valid = 1'b0;
        wait_wr_ok(1'b0);
        rd_valid = 1'b1;
        rd_size  = SIZE_8;
        wait_rd_ready(1'b1);
        repeat (5) begin
            @(negedge clock);
            assert (rd_ready === 1'b1) else report_error("rd_ready_o fell while read was held");
            check_read(64'hc0);
        end
        rd_valid = 1'b0;
        wait_rd_ready(1'b0);
    endtask

    task automatic test_full_word();
        logic [63:0] got;
        do_write(64'h40, 64'h0123_4567_89ab_cdef, 8'hff, SIZE_8);
        do_read(64'h40, got);
        assert (got === 64'h0123_4567_89ab_cdef) else report_error("full word read-back differs");
    endtask

    task automatic test_byte_write();
        logic [63:0] got;
        do_write(64'h80, 64'hffee_ddcc_bbaa_9988, 8'hff, SIZE_8);
        do_write(64'h85, 64'h1111_2222_3333_445a, 8'h01, SIZE_1); // only 5a lands in byte 5
        do_read(64'h80, got);
        assert (got === 64'hffee_5acc_bbaa_9988) else
            report_error($sformatf("byte write at offset 5 gave 0x%016h", got));
    endtask

    task automatic test_addr_change();
        do_write(64'h100, 64'haaaa_0000_1111_2222, 8'hff, SIZE_8);
        do_write(64'h108, 64'h5555_3333_4444_6666, 8'hff, SIZE_8);
        rd_valid = 1'b1;
        addr     = 64'h100;
        rd_size  = SIZE_8;
        wait_rd_ready(1'b1);
        check_read(64'h100);
        addr = 64'h108; // valid stays high
        #1;
        assert (rd_ready === 1'b0) else
            report_error("rd_ready_o stayed high after the address changed");
        wait_rd_ready(1'b0);
        wait_rd_ready(1'b1);
        check_read(64'h108);
        rd_valid = 1'b0;
        wait_rd_ready(1'b0);
    endtask

    task automatic test_random();
        logic [63:0] base;
        logic [63:0] a;
        logic [63:0] d;
        logic [63:0] got;
        logic [7:0]  m;
        int          k;
        int          nbytes;
        int          off;
        int          w;
        base = 64'h200;
        for (w = 0; w < 8; w++) begin
            do_write(base + 8 * w, {$random(seed), $random(seed)}, 8'hff, SIZE_8);
        end
        for (int i = 0; i < 20; i++) begin
            k      = $unsigned($random(seed)) % 4;
            nbytes = 1 << k;
            off    = $unsigned($random(seed)) % (9 - nbytes); // stays inside one word
            w      = $unsigned($random(seed)) % 8;
            a      = base + 8 * w + off;
            d      = {$random(seed), $random(seed)};
            m      = (1 << nbytes) - 1;
            do_write(a, d, m, axi_size_e'(k));
        end
        for (w = 0; w < 8; w++) begin
            do_read(base + 8 * w, got);
        end
    endtask

    // addr_i is shared so both requests carry the same address
    task automatic test_same_cycle();
        do_write(64'h300, 64'h7777_8888_9999_aaaa, 8'hff, SIZE_8);
        wr_valid = 1'b1;
        rd_valid = 1'b1;
        addr     = 64'h300;
        wr_data  = 64'h0000_0000_dead_beef;
        wr_mask  = 8'h0f;
        wr_size  = SIZE_4;
        rd_size  = SIZE_8;
        wait_both_done();
        model_write(64'h300, 64'h0000_0000_dead_beef, 8'h0f); // write wins at the sram
        check_read(64'h300);
        wr_valid = 1'b0;
        rd_valid = 1'b0;
        wait_wr_ok(1'b0);
        wait_rd_ready(1'b0);
    endtask

    initial begin
        clock    = 1'b0;
        reset    = 1'b0;
        wr_valid = 1'b0;
        rd_valid = 1'b0;
        addr     = '0;
        wr_data  = '0;
        wr_mask  = '0;
        wr_size  = SIZE_8;
        rd_size  = SIZE_8;
        seed     = 3;
        repeat (2) @(posedge clock);
        @(negedge clock);
        reset = 1'b1;

        test_hold_levels();
        test_full_word();
        test_byte_write();
        test_addr_change();
        test_random();
        test_same_cycle();

        $display("Simulation PASSED");
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+common
common/axi_pkg.sv
common/lsu_pkg.sv
axi_ls/axi_ls.sv
verilog/axi_sram.sv
verilog/ls_subsys_top.sv
verif/tb_ls_subsys.sv

// ==== Bender.yml ====
package:
  name: ls_subsys

export_include_dirs:
  - common

sources:
  - files:
      - common/axi_pkg.sv
      - common/lsu_pkg.sv
      - axi_ls/axi_ls.sv
      - verilog/axi_sram.sv
      - verilog/ls_subsys_top.sv

  - target: test
    files:
      - verif/tb_ls_subsys.sv
